/* source/tcdm_pkg.sv */
package tcdm_pkg;

  // word-addressed bank, 32-bit words with byte enables.
  localparam int unsigned TCDM_AW = 10; // address width in words.
  localparam int unsigned TCDM_DW = 32; // data width.
  localparam int unsigned TCDM_BW = 4;  // one enable per byte.

  typedef logic [TCDM_AW-1:0] addr_t;
  typedef logic [TCDM_DW-1:0] data_t;
  typedef logic [TCDM_BW-1:0] be_t;
  typedef logic [TCDM_AW-1:0] len_t; // block length in words, 0 is an empty copy.

  // request from an initiator towards the bank.
  typedef struct packed {
    logic  req;  // request valid.
    addr_t add;  // word address.
    logic  wen;  // 1 = read, 0 = write.
    be_t   be;   // byte enables, writes only.
    data_t data; // write data.
  } tcdm_req_t;

  // response from the bank back to an initiator.
  typedef struct packed {
    logic  gnt;     // request accepted this cycle.
    logic  r_valid; // read data valid, one cycle after the grant.
    data_t r_data;
  } tcdm_rsp_t;

  // multiplexer select, one value per initiator.
  typedef logic [1:0] sel_t;

  localparam sel_t SEL_HOST  = 2'd0;
  localparam sel_t SEL_LOAD  = 2'd1;
  localparam sel_t SEL_STORE = 2'd2;

  // copy controller states.
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STORE,
    DONE
  } copy_state_e;

endpackage

/* source/tcdm_mux_static.sv */
`timescale 1ns/100ps

// static multiplexer for initiators that never overlap in time.
// no arbitration, the select alone decides who owns the bank.
module tcdm_mux_static #(
  parameter int unsigned NB_CHAN = 3
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  tcdm_pkg::sel_t                      sel_i,
  input  tcdm_pkg::tcdm_req_t [NB_CHAN-1:0]   in_req_i,
  output tcdm_pkg::tcdm_rsp_t [NB_CHAN-1:0]   in_rsp_o,
  output tcdm_pkg::tcdm_req_t                 out_req_o,
  input  tcdm_pkg::tcdm_rsp_t                 out_rsp_i
);

  import tcdm_pkg::*;

  // forward the selected request, an idle request otherwise.
  always_comb begin
    out_req_o = '0;
    for (int ii = 0; ii < NB_CHAN; ii++) begin
      if (sel_i == sel_t'(ii)) begin
        out_req_o = in_req_i[ii];
      end
    end
  end

  // gnt and r_valid go to the owner only.
  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_rsp
    logic chan_sel; // this channel owns the bank.

    assign chan_sel = (sel_i == sel_t'(ii));

    assign in_rsp_o[ii] = '{
      gnt:     chan_sel & out_rsp_i.gnt,
      r_valid: chan_sel & out_rsp_i.r_valid,
      r_data:  out_rsp_i.r_data // broadcast, qualified by r_valid.
    };
  end

  // the select must name an existing channel.
  sel_range_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    32'(sel_i) < NB_CHAN
  );

  // a switch right after a granted read would hand its data to the wrong owner.
  sel_hold_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (out_req_o.req && out_req_o.wen && out_rsp_i.gnt) |=> $stable(sel_i)
  );

endmodule

/* source/tcdm_load_port.sv */
`timescale 1ns/100ps

// read initiator, fetches len words from base into a local buffer.
// issue and response side count separately so reads stay pipelined.
module tcdm_load_port #(
  parameter int unsigned BUF_DEPTH = 16
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  tcdm_pkg::addr_t     base_i,
  input  tcdm_pkg::len_t      len_i,
  output tcdm_pkg::tcdm_req_t req_o,
  input  tcdm_pkg::tcdm_rsp_t rsp_i,
  input  tcdm_pkg::len_t      buf_raddr_i,
  output tcdm_pkg::data_t     buf_rdata_o,
  output logic                done_o
);

  import tcdm_pkg::*;

  localparam int unsigned BUF_AW = $clog2(BUF_DEPTH);

  data_t buf_q [BUF_DEPTH]; // local copy of the block.

  len_t issue_cnt_q; // reads granted so far.
  len_t resp_cnt_q;  // words written into the buffer.
  logic issuing_q;   // req held high.
  logic busy_q;      // waiting for responses.
  logic done_q;
  logic last_issue;
  logic last_resp;
  logic resp_take;

  assign last_issue = (issue_cnt_q == len_t'(len_i - len_t'(1)));
  assign last_resp  = (resp_cnt_q == len_t'(len_i - len_t'(1)));
  assign resp_take  = busy_q & rsp_i.r_valid;

  // full-word read at base + issue count.
  assign req_o = '{
    req:  issuing_q,
    add:  addr_t'(base_i + issue_cnt_q),
    wen:  1'b1,
    be:   '1,
    data: '0
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue_cnt_q <= '0;
      resp_cnt_q  <= '0;
      issuing_q   <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0; // single-cycle pulse.
      if (start_i) begin
        issue_cnt_q <= '0;
        resp_cnt_q  <= '0;
        issuing_q   <= 1'b1;
        busy_q      <= 1'b1;
      end else begin
        if (issuing_q && rsp_i.gnt) begin
          issue_cnt_q <= issue_cnt_q + len_t'(1);
          if (last_issue) issuing_q <= 1'b0; // all reads granted.
        end
        if (resp_take) begin
          resp_cnt_q <= resp_cnt_q + len_t'(1);
          if (last_resp) begin
            busy_q <= 1'b0;
            done_q <= 1'b1; // cycle after the last r_valid.
          end
        end
      end
    end
  end

  // buffer fill, one word per r_valid.
  always_ff @(posedge clk_i) begin
    if (resp_take) buf_q[resp_cnt_q[BUF_AW-1:0]] <= rsp_i.r_data;
  end

  assign buf_rdata_o = buf_q[buf_raddr_i[BUF_AW-1:0]]; // combinational read side.
  assign done_o      = done_q;

  // the controller starts only non-empty blocks that fit the buffer.
  len_fits_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    start_i |-> (len_i != '0) && (32'(len_i) <= BUF_DEPTH)
  );

endmodule

/* source/tcdm_store_port.sv */
`timescale 1ns/100ps

// write initiator, drains the load buffer to len consecutive words at base.
module tcdm_store_port (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  tcdm_pkg::addr_t     base_i,
  input  tcdm_pkg::len_t      len_i,
  output tcdm_pkg::tcdm_req_t req_o,
  input  tcdm_pkg::tcdm_rsp_t rsp_i,
  output tcdm_pkg::len_t      buf_raddr_o,
  input  tcdm_pkg::data_t     buf_rdata_i,
  output logic                done_o
);

  import tcdm_pkg::*;

  len_t cnt_q;    // words written, also the buffer index.
  logic active_q; // req held high.
  logic done_q;
  logic last_word;

  assign last_word = (cnt_q == len_t'(len_i - len_t'(1)));

  assign buf_raddr_o = cnt_q; // buffer word for the current request.

  // full-word write, data follows the counter.
  assign req_o = '{
    req:  active_q,
    add:  addr_t'(base_i + cnt_q),
    wen:  1'b0,
    be:   '1,
    data: buf_rdata_i
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        cnt_q    <= '0;
        active_q <= 1'b1;
      end else if (active_q && rsp_i.gnt) begin
        cnt_q <= cnt_q + len_t'(1); // next word only after the grant.
        if (last_word) begin
          active_q <= 1'b0;
          done_q   <= 1'b1; // cycle after the last grant.
        end
      end
    end
  end

  assign done_o = done_q;

  // the load phase has fully drained before the store port gets the bank.
  no_read_data_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    active_q |-> !rsp_i.r_valid
  );

endmodule

/* source/copy_ctrl.sv */
`timescale 1ns/100ps

// sequences host, load and store use of the bank.
// the bank select is a pure function of the state.
module copy_ctrl (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           start_i,
  input  tcdm_pkg::len_t len_i,
  input  logic           load_done_i,
  input  logic           store_done_i,
  output logic           load_start_o,
  output logic           store_start_o,
  output tcdm_pkg::sel_t sel_o,
  output logic           busy_o,
  output logic           done_o
);

  import tcdm_pkg::*;

  copy_state_e state_q;
  copy_state_e state_d;
  logic        load_start_q;  // first cycle of LOAD.
  logic        store_start_q; // first cycle of STORE.

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = (len_i == '0) ? DONE : LOAD; // empty copy skips both phases.
      LOAD:    if (load_done_i) state_d = STORE;
      STORE:   if (store_done_i) state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= IDLE;
      load_start_q  <= 1'b0;
      store_start_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      load_start_q  <= (state_q == IDLE) && start_i && (len_i != '0);
      store_start_q <= (state_q == LOAD) && load_done_i;
    end
  end

  // bank owner per state.
  always_comb begin
    case (state_q)
      LOAD:    sel_o = SEL_LOAD;
      STORE:   sel_o = SEL_STORE;
      DONE:    sel_o = SEL_STORE; // store port is idle, host still locked out.
      default: sel_o = SEL_HOST;
    endcase
  end

  assign load_start_o  = load_start_q;
  assign store_start_o = store_start_q;
  assign busy_o        = (state_q != IDLE);
  assign done_o        = (state_q == DONE); // one cycle, end of every copy.

  // load completion only while the load port owns the bank.
  load_done_state_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    load_done_i |-> (state_q == LOAD)
  );

endmodule

/* source/tcdm_bank.sv */
`timescale 1ns/100ps

// single-port word memory with a stall-driven grant.
// writes land in the grant cycle, reads return one cycle later.
module tcdm_bank #(
  parameter int unsigned MEM_DEPTH = 1024
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                stall_i,
  input  tcdm_pkg::tcdm_req_t req_i,
  output tcdm_pkg::tcdm_rsp_t rsp_o
);

  import tcdm_pkg::*;

  localparam int unsigned MEM_AW = $clog2(MEM_DEPTH);

  data_t              mem_q [MEM_DEPTH];
  logic [MEM_AW-1:0]  word_idx;
  logic               gnt;
  logic               r_valid_q;
  data_t              r_data_q;

  assign word_idx = req_i.add[MEM_AW-1:0];
  assign gnt      = req_i.req & ~stall_i; // stall is the only back-pressure.

  always_ff @(posedge clk_i) begin
    if (gnt && !req_i.wen) begin
      for (int b = 0; b < TCDM_BW; b++) begin
        if (req_i.be[b]) mem_q[word_idx][8*b +: 8] <= req_i.data[8*b +: 8]; // enabled bytes only.
      end
    end
    if (gnt && req_i.wen) begin
      r_data_q <= mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt & req_i.wen; // one pulse per granted read.
    end
  end

  assign rsp_o = '{
    gnt:     gnt,
    r_valid: r_valid_q,
    r_data:  r_data_q
  };

  // a stalled request stays on the bus unchanged until it is granted.
  stall_hold_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (req_i.req && stall_i) |=> $stable(req_i)
  );

endmodule

/* source/block_copy_top.sv */
`timescale 1ns/100ps

// block copy engine on one tcdm bank.
module block_copy_top #(
  parameter int unsigned MEM_DEPTH = 1024,
  parameter int unsigned BUF_DEPTH = 16,
  parameter int unsigned NB_CHAN   = 3
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  tcdm_pkg::addr_t     src_i,
  input  tcdm_pkg::addr_t     dst_i,
  input  tcdm_pkg::len_t      len_i,
  input  logic                stall_i,
  input  tcdm_pkg::tcdm_req_t host_req_i,
  output tcdm_pkg::tcdm_rsp_t host_rsp_o,
  output logic                busy_o,
  output logic                done_o
);

  import tcdm_pkg::*;

  // copy parameters, held for the whole copy.
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } copy_par_t;

  copy_par_t                 par_q;
  sel_t                      sel;
  tcdm_req_t [NB_CHAN-1:0]   mux_req;
  tcdm_rsp_t [NB_CHAN-1:0]   mux_rsp;
  tcdm_req_t                 bank_req;
  tcdm_rsp_t                 bank_rsp;
  logic                      load_start;
  logic                      store_start;
  logic                      load_done;
  logic                      store_done;
  len_t                      buf_raddr;
  data_t                     buf_rdata;

  // capture on an accepted start, same condition as the controller.
  always_ff @(posedge clk_i) begin
    if (start_i && !busy_o) par_q <= '{src: src_i, dst: dst_i, len: len_i};
  end

  assign mux_req[SEL_HOST] = host_req_i;
  assign host_rsp_o        = mux_rsp[SEL_HOST];

  copy_ctrl i_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (start_i),
    .len_i         (len_i), // raw length, decides the empty-copy path.
    .load_done_i   (load_done),
    .store_done_i  (store_done),
    .load_start_o  (load_start),
    .store_start_o (store_start),
    .sel_o         (sel),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  tcdm_load_port #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_load (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (load_start),
    .base_i      (par_q.src),
    .len_i       (par_q.len),
    .req_o       (mux_req[SEL_LOAD]),
    .rsp_i       (mux_rsp[SEL_LOAD]),
    .buf_raddr_i (buf_raddr),
    .buf_rdata_o (buf_rdata),
    .done_o      (load_done)
  );

  tcdm_store_port i_store (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (store_start),
    .base_i      (par_q.dst),
    .len_i       (par_q.len),
    .req_o       (mux_req[SEL_STORE]),
    .rsp_i       (mux_rsp[SEL_STORE]),
    .buf_raddr_o (buf_raddr),
    .buf_rdata_i (buf_rdata),
    .done_o      (store_done)
  );

  tcdm_mux_static #(
    .NB_CHAN (NB_CHAN)
  ) i_mux (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sel_i     (sel),
    .in_req_i  (mux_req),
    .in_rsp_o  (mux_rsp),
    .out_req_o (bank_req),
    .out_rsp_i (bank_rsp)
  );

  tcdm_bank #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_bank (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .stall_i (stall_i),
    .req_i   (bank_req),
    .rsp_o   (bank_rsp)
  );

endmodule

/* testbench/block_copy_tb.sv */
`timescale 1ns/100ps

// testbench for the block copy engine, driven by a command file.
module block_copy_tb;

  import tcdm_pkg::*;

  localparam int unsigned MEM_DEPTH = 1024;
  localparam int unsigned BUF_DEPTH = 16;
  localparam int unsigned NB_CHAN   = 3;
  localparam int          TIMEOUT   = 200; // cycles per wait.

  logic      clk_i;
  logic      reset_i;
  logic      start_i;
  addr_t     src_i;
  addr_t     dst_i;
  len_t      len_i;
  logic      stall_i;
  tcdm_req_t host_req_i;
  tcdm_rsp_t host_rsp_o;
  logic      busy_o;
  logic      done_o;

  int   errors;
  int   checks;
  logic abort;    // set on a timeout, ends the command loop.
  logic stall_on; // random stall mode.
  int   seed = 32'hc293_56fe;
  int   rnd;

  block_copy_top #(
    .MEM_DEPTH (MEM_DEPTH),
    .BUF_DEPTH (BUF_DEPTH),
    .NB_CHAN   (NB_CHAN)
  ) dut0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (start_i),
    .src_i      (src_i),
    .dst_i      (dst_i),
    .len_i      (len_i),
    .stall_i    (stall_i),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period.
  end

  // bank stall, new random bit on every falling edge while enabled.
  initial begin
    stall_i = 1'b0;
    forever begin
      @(negedge clk_i);
      rnd     = $random(seed);
      stall_i = stall_on & rnd[0];
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s exp %h got %h", name, exp, got);
    end
  endtask

  // holds the request until granted, then drops it.
  task automatic host_write(input addr_t addr, input be_t be, input data_t data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    host_req_i = '{req: 1'b1, add: addr, wen: 1'b0, be: be, data: data};
    #1;
    while (!host_rsp_o.gnt && waited < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!host_rsp_o.gnt) begin
      errors++;
      abort = 1'b1;
      $display("host write to address %h was never granted", addr);
    end
    @(negedge clk_i);
    host_req_i = '0;
  endtask

  task automatic host_read(input addr_t addr, output data_t data);
    int   waited;
    logic granted;
    waited = 0;
    data   = '0;
    @(negedge clk_i);
    host_req_i = '{req: 1'b1, add: addr, wen: 1'b1, be: '1, data: '0};
    #1;
    while (!host_rsp_o.gnt && waited < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    granted = host_rsp_o.gnt;
    @(negedge clk_i);
    host_req_i = '0; // read data shows up in this cycle.
    #1;
    if (!granted) begin
      errors++;
      abort = 1'b1;
      $display("host read from address %h was never granted", addr);
      return;
    end
    waited = 0;
    while (!host_rsp_o.r_valid && waited < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!host_rsp_o.r_valid) begin
      errors++;
      abort = 1'b1;
      $display("host read from address %h returned no data", addr);
    end
    data = host_rsp_o.r_data;
  endtask

  // one copy, host holds a read request the whole time to probe the lockout.
  task automatic run_copy(input addr_t src, input addr_t dst, input len_t len);
    int waited;
    int pulses;
    waited = 0;
    pulses = 0;
    @(negedge clk_i);
    start_i = 1'b1;
    src_i   = src;
    dst_i   = dst;
    len_i   = len;
    #1;
    check_value("busy_o", 32'd0, 32'(busy_o));
    @(negedge clk_i);
    start_i    = 1'b0;
    host_req_i = '{req: 1'b1, add: src, wen: 1'b1, be: '1, data: '0};
    #1;
    while (!done_o && waited < TIMEOUT) begin
      check_value("busy_o", 32'd1, 32'(busy_o));
      check_value("host_rsp_o.gnt", 32'd0, 32'(host_rsp_o.gnt)); // bank owned by the engine.
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!done_o) begin
      errors++;
      abort = 1'b1;
      $display("copy from %h to %h never signalled done", src, dst);
      @(negedge clk_i);
      host_req_i = '0;
      return;
    end
    check_value("host_rsp_o.gnt", 32'd0, 32'(host_rsp_o.gnt)); // still locked while done.
    @(negedge clk_i);
    #1;
    check_value("busy_o", 32'd0, 32'(busy_o)); // first idle cycle.
    waited = 0;
    while (!host_rsp_o.gnt && waited < TIMEOUT) begin
      if (done_o) pulses++;
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (done_o) pulses++;
    check_value("done_o extra pulses", 32'd0, 32'(pulses));
    if (!host_rsp_o.gnt) begin
      errors++;
      abort = 1'b1;
      $display("host port was not granted again after the copy");
    end
    @(negedge clk_i);
    host_req_i = '0;
  endtask

  initial begin : main
    int          fd;
    int          code;
    int          ch;
    logic [7:0]  cmd;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    data_t       rdata;
    logic        bad_line;
    errors     = 0;
    checks     = 0;
    abort      = 1'b0;
    stall_on   = 1'b0;
    reset_i    = 1'b1;
    start_i    = 1'b0;
    src_i      = '0;
    dst_i      = '0;
    len_i      = '0;
    host_req_i = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    check_value("busy_o", 32'd0, 32'(busy_o)); // idle after reset.
    check_value("done_o", 32'd0, 32'(done_o));
    check_value("host_rsp_o.gnt", 32'd0, 32'(host_rsp_o.gnt));
    fd = $fopen("testbench/block_copy_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      abort = 1'b1;
      $display("could not open the stimulus file");
    end
    while (!abort) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) break; // end of file.
      bad_line = 1'b0;
      case (cmd)
        "#": begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) ch = $fgetc(fd); // rest of the comment line.
        end
        "W": begin
          code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (code == 3) host_write(addr_t'(f1), be_t'(f2), f3);
          else bad_line = 1'b1;
        end
        "R": begin
          code = $fscanf(fd, "%h %h", f1, f2);
          if (code == 2) begin
            host_read(addr_t'(f1), rdata);
            if (!abort) check_value($sformatf("mem[%h]", addr_t'(f1)), f2, rdata);
          end else begin
            bad_line = 1'b1;
          end
        end
        "C": begin
          code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (code == 3) run_copy(addr_t'(f1), addr_t'(f2), len_t'(f3));
          else bad_line = 1'b1;
        end
        "S": begin
          code = $fscanf(fd, "%h", f1);
          if (code == 1) stall_on = f1[0];
          else bad_line = 1'b1;
        end
        default: bad_line = 1'b1;
      endcase
      if (bad_line) begin
        errors++;
        abort = 1'b1;
        $display("stimulus line for command %c could not be parsed", cmd);
      end
    end
    if (fd != 0) $fclose(fd);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* testbench/block_copy_stimulus.txt */
# columns in hex: W addr be data | R addr expected | C src dst len | S stall_on
# W and R go through the host port, C runs one copy, S switches random bank stall.
W 000 f 12345678
R 000 12345678
W 000 5 aabbccdd
R 000 12bb56dd
W 010 f 11110000
W 011 f 22221111
W 012 f 33332222
W 013 f 44443333
W 024 f 0badf00d
C 010 020 4
R 020 11110000
R 021 22221111
R 022 33332222
R 023 44443333
R 024 0badf00d
C 013 020 0
R 020 11110000
S 1
W 014 f 55554444
W 015 f 66665555
W 016 f 77776666
W 017 f 88887777
W 018 f 99998888
W 019 f aaaa9999
W 01a f bbbbaaaa
W 01b f ccccbbbb
W 01c f ddddcccc
W 01d f eeeedddd
W 01e f ffffeeee
W 01f f 0000ffff
W 050 f cafef00d
C 010 040 10
R 040 11110000
R 045 66665555
R 047 88887777
R 04b ccccbbbb
R 04f 0000ffff
R 050 cafef00d
C 01d 060 3
R 060 eeeedddd
R 062 0000ffff
S 0
R 000 12bb56dd

/* build.f */
source/tcdm_pkg.sv
source/tcdm_mux_static.sv
source/tcdm_load_port.sv
source/tcdm_store_port.sv
source/copy_ctrl.sv
source/tcdm_bank.sv
source/block_copy_top.sv
testbench/block_copy_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the block copy testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=block_copy_sim

verilator --binary --timing --assert -f build.f --top-module block_copy_tb \
  --Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench result decides the script status.
if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
